/* Makefile */
# Verilator build and run of the AHB-Lite to AXI4-Lite bridge testbench
SRCS := $(shell cat vlog.f)

.PHONY: run clean

run: obj_dir/Vtb_ahb_axi_bridge
	@out="$$(./obj_dir/Vtb_ahb_axi_bridge)"; echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

obj_dir/Vtb_ahb_axi_bridge: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ahb_axi_bridge -f vlog.f

clean:
	rm -rf obj_dir

/* rtl/ahb_axi_bridge.sv */
/* AHB-Lite slave to AXI4-Lite master bridge, top level. Plain bus ports,
   the decode, execute and result stages joined by two interfaces */
`timescale 1ns/1ps

module ahb_axi_bridge import ahb_axi_pkg::*; (
  input  logic              bus_clk,
  input  logic              rst_l,

  // AHB-Lite slave
  input  logic              hsel,
  input  logic [addr_w-1:0] haddr,
  input  logic              hwrite,
  input  logic [2:0]        hsize,
  input  logic [1:0]        htrans,
  input  logic [data_w-1:0] hwdata,
  input  logic              hreadyin,
  output logic              hreadyout,
  output logic [data_w-1:0] hrdata,
  output logic              hresp,

  // AXI4-Lite master, write
  output logic [addr_w-1:0] awaddr,
  output logic              awvalid,
  input  logic              awready,
  output logic [data_w-1:0] wdata,
  output logic [strb_w-1:0] wstrb,
  output logic              wvalid,
  input  logic              wready,
  output logic              bready,

  // AXI4-Lite master, read
  output logic [addr_w-1:0] araddr,
  output logic              arvalid,
  input  logic              arready,
  input  logic [data_w-1:0] rdata,
  input  logic [1:0]        rresp,
  input  logic              rvalid,
  output logic              rready
);

  bridge_cmd_if cmd_if ();  // Decode to execute
  bridge_rsp_if rsp_if ();  // Execute and result

  ahb_decode u_decode (
    .bus_clk  (bus_clk),
    .rst_l    (rst_l),
    .hsel     (hsel),
    .haddr    (haddr),
    .hwrite   (hwrite),
    .hsize    (hsize_e'(hsize)),
    .htrans   (htrans_e'(htrans)),
    .hreadyin (hreadyin),
    .cmd      (cmd_if.dec)
  );

  bridge_execute u_execute (
    .bus_clk   (bus_clk),
    .rst_l     (rst_l),
    .cmd       (cmd_if.exec),
    .rsp       (rsp_if.exec),
    .hwdata    (hwdata),
    .hreadyout (hreadyout),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready)
  );

  read_result u_result (
    .bus_clk (bus_clk),
    .rst_l   (rst_l),
    .rsp     (rsp_if.res),
    .cmd_err (cmd_if.err),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .hrdata  (hrdata),
    .hresp   (hresp)
  );

endmodule

/* rtl/ahb_axi_pkg.sv */
/* Widths, tightly coupled memory windows, enums and the byte-strobe rule
   shared by the AHB-Lite to AXI4-Lite bridge and its testbench */
package ahb_axi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////
  localparam int addr_w = 32;  // AHB and AXI address
  localparam int data_w = 64;  // Data bus, both sides
  localparam int strb_w = 8;   // One strobe per byte lane

  //////////////////////////////////////////////////////////////////////
  // Memory windows
  //////////////////////////////////////////////////////////////////////
  localparam logic [addr_w-1:0] iccm_base = 32'hEE00_0000;  // ICCM, 64 KiB
  localparam logic [addr_w-1:0] dccm_base = 32'hF004_0000;  // DCCM, 64 KiB
  localparam int win_bits = 16;  // log2 of window size, low bits ignored in decode

  localparam logic [1:0] resp_okay = 2'b00;  // AXI OKAY

  // AHB HTRANS encoding
  typedef enum logic [1:0] {
    idle   = 2'b00,
    busy   = 2'b01,
    nonseq = 2'b10,
    seq    = 2'b11
  } htrans_e;

  // AHB HSIZE, only up to a double word is supported
  typedef enum logic [2:0] {
    size_byte  = 3'b000,
    size_half  = 3'b001,
    size_word  = 3'b010,
    size_dword = 3'b011
  } hsize_e;

  // Bridge transfer state
  typedef enum logic [1:0] {
    st_idle = 2'b00,  // Nothing outstanding
    st_wr   = 2'b01,  // Write held in the command buffer, AW and/or W owed
    st_rd   = 2'b10,  // Read held in the command buffer, AR owed
    st_pend = 2'b11   // AR done, waiting on R
  } bridge_state_e;

  // Byte lanes touched by a transfer of this size at this low address
  function automatic logic [strb_w-1:0] size_strobe(hsize_e size, logic [2:0] lo);
    case (size)
      size_byte:  return 8'h01 << lo;
      size_half:  return 8'h03 << lo;
      size_word:  return 8'h0f << lo;
      size_dword: return 8'hff;  // Full bus, address is aligned anyway
      default:    return '0;
    endcase
  endfunction

endpackage

/* rtl/ahb_decode.sv */
/* Address-phase capture for the bridge. Registers each accepted AHB
   transfer, checks it against the ICCM/DCCM windows, size and alignment,
   and forms the write byte strobes */
`timescale 1ns/1ps

module ahb_decode import ahb_axi_pkg::*; (
  input  logic              bus_clk,
  input  logic              rst_l,
  input  logic              hsel,
  input  logic [addr_w-1:0] haddr,
  input  logic              hwrite,
  input  hsize_e            hsize,
  input  htrans_e           htrans,
  input  logic              hreadyin,
  bridge_cmd_if.dec         cmd
);

  logic hready;      // Bus moves on this cycle
  logic addr_phase;  // NONSEQ or SEQ aimed at this slave
  logic in_iccm;
  logic in_dccm;
  logic bad_region;  // Outside both windows
  logic bad_size;    // Sub-word where only word/dword allowed
  logic bad_align;   // Address not a multiple of the size

  assign hready     = cmd.accept & hreadyin;
  assign addr_phase = hsel & ((htrans == nonseq) | (htrans == seq));  // BUSY/IDLE ignored

  //////////////////////////////////////////////////////////////////////
  // Address phase registers
  //////////////////////////////////////////////////////////////////////

  // Data phase flag, held while hready is low
  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      cmd.valid <= 1'b0;
    end else if (hready) begin
      cmd.valid <= addr_phase;
    end
  end

  // Transfer attributes, only loaded on an accepted address phase
  always_ff @(posedge bus_clk) begin
    if (hready && addr_phase) begin
      cmd.write <= hwrite;
      cmd.size  <= hsize;
      cmd.addr  <= haddr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks on the registered address
  //////////////////////////////////////////////////////////////////////

  // Window match on the bits above the window size
  assign in_iccm = (cmd.addr[addr_w-1:win_bits] == iccm_base[addr_w-1:win_bits]);
  assign in_dccm = (cmd.addr[addr_w-1:win_bits] == dccm_base[addr_w-1:win_bits]);

  assign bad_region = ~(in_iccm | in_dccm);

  // ICCM any access, DCCM writes: word or double word only
  assign bad_size = (in_iccm | (in_dccm & cmd.write)) &
                    ~((cmd.size == size_word) | (cmd.size == size_dword));

  always_comb begin
    case (cmd.size)
      size_half:  bad_align = cmd.addr[0];
      size_word:  bad_align = |cmd.addr[1:0];
      size_dword: bad_align = |cmd.addr[2:0];
      default:    bad_align = 1'b0;  // Bytes are always aligned
    endcase
  end

  assign cmd.err  = cmd.valid & (bad_region | bad_size | bad_align);
  assign cmd.strb = size_strobe(cmd.size, cmd.addr[2:0]);  // Lanes for W

endmodule

/* rtl/bridge_cmd_if.sv */
/* Decoded AHB transfer handed from the decode stage to the execute stage;
   a transfer is consumed on the edge where valid and accept are both high */
`timescale 1ns/1ps

interface bridge_cmd_if import ahb_axi_pkg::*; ();

  logic              valid;   // Data phase of an accepted transfer
  logic              write;   // 1 = write, 0 = read
  hsize_e            size;    // Registered HSIZE
  logic [addr_w-1:0] addr;    // Registered HADDR
  logic [strb_w-1:0] strb;    // Byte lanes from size and addr
  logic              err;     // Failed window, size or alignment check
  logic              accept;  // Bus side may advance, this is hreadyout

  // Decode side
  modport dec (
    output valid, write, size, addr, strb, err,
    input  accept
  );

  // Execute side
  modport exec (
    input  valid, write, size, addr, strb, err,
    output accept
  );

endinterface

/* rtl/bridge_execute.sv */
/* Transfer FSM and one-entry command buffer. Drives AXI4-Lite AW, W and
   AR from the buffer and decides when the AHB data phase may end */
`timescale 1ns/1ps

module bridge_execute import ahb_axi_pkg::*; (
  input  logic              bus_clk,
  input  logic              rst_l,
  bridge_cmd_if.exec        cmd,
  bridge_rsp_if.exec        rsp,
  input  logic [data_w-1:0] hwdata,
  output logic              hreadyout,
  output logic [addr_w-1:0] awaddr,
  output logic              awvalid,
  input  logic              awready,
  output logic [data_w-1:0] wdata,
  output logic [strb_w-1:0] wstrb,
  output logic              wvalid,
  input  logic              wready,
  output logic              bready,
  output logic [addr_w-1:0] araddr,
  output logic              arvalid,
  input  logic              arready
);

  bridge_state_e state;
  bridge_state_e state_nxt;

  logic              aw_pend;   // AW not yet handshaken
  logic              w_pend;    // W not yet handshaken
  logic [addr_w-1:0] buf_addr;  // Command buffer payload
  logic [data_w-1:0] buf_data;
  logic [strb_w-1:0] buf_strb;
  logic              wr_free;   // Last owed write handshake this cycle
  logic              wr_load;   // Write enters the buffer
  logic              rd_load;   // Read enters the buffer
  logic              rd_ready;  // R data registered, AHB may finish the read
  logic              err_seen;  // First ERROR cycle already given
  logic              consumed;  // AHB data phase ends on this edge

  assign rsp.state    = state;
  assign wr_free      = (state == st_wr) & (~aw_pend | awready) & (~w_pend | wready);
  assign rsp.buf_full = ((state == st_wr) & ~wr_free) | (state == st_rd);

  //////////////////////////////////////////////////////////////////////
  // AHB ready
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if (rsp.hresp)
      hreadyout = err_seen;          // Low then high for ERROR
    else if (!cmd.valid)
      hreadyout = 1'b1;              // No data phase for us
    else if (cmd.write)
      hreadyout = ~rsp.buf_full;     // Posted write, needs a free buffer
    else
      hreadyout = rd_ready;          // Reads block until R returns
  end

  assign cmd.accept = hreadyout;
  assign consumed   = cmd.valid & hreadyout;

  // Buffer loads, never for a transfer that failed decode
  assign wr_load = consumed & cmd.write & ~cmd.err;
  assign rd_load = cmd.valid & ~cmd.write & ~cmd.err & ~rd_ready &
                   ~rsp.buf_full & (state != st_pend);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle, st_wr: begin
        if (wr_load) state_nxt = st_wr;       // Back-to-back write refills
        else if (rd_load) state_nxt = st_rd;
        else if (wr_free) state_nxt = st_idle;
      end
      st_rd: begin
        if (arvalid && arready) state_nxt = st_pend;
      end
      st_pend: begin
        if (rsp.rd_done) state_nxt = st_idle;  // Data shows next cycle
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      state    <= st_idle;
      aw_pend  <= 1'b0;
      w_pend   <= 1'b0;
      rd_ready <= 1'b0;
      err_seen <= 1'b0;
    end else begin
      state    <= state_nxt;
      aw_pend  <= wr_load | (aw_pend & ~awready);  // AW and W retire separately
      w_pend   <= wr_load | (w_pend & ~wready);
      rd_ready <= rsp.rd_done | (rd_ready & ~consumed);
      err_seen <= rsp.hresp & ~hreadyout;
    end
  end

  // Command buffer payload
  always_ff @(posedge bus_clk) begin
    if (wr_load || rd_load)
      buf_addr <= cmd.addr;
    if (wr_load) begin
      buf_data <= hwdata;  // HWDATA is valid in the data phase
      buf_strb <= cmd.strb;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite drive
  //////////////////////////////////////////////////////////////////////
  assign awaddr  = buf_addr;
  assign awvalid = aw_pend;
  assign wdata   = buf_data;
  assign wstrb   = buf_strb;
  assign wvalid  = w_pend;
  assign bready  = 1'b1;       // Posted writes, BRESP not looked at
  assign araddr  = buf_addr;
  assign arvalid = (state == st_rd);

endmodule

/* rtl/bridge_rsp_if.sv */
/* Read completion, error and FSM state passed between the execute
   stage and the result stage */
`timescale 1ns/1ps

interface bridge_rsp_if import ahb_axi_pkg::*; ();

  bridge_state_e state;     // Execute FSM state
  logic          buf_full;  // Command buffer cannot take a new entry
  logic          rd_done;   // R handshake while in st_pend
  logic          rd_err;    // Read error, held over both ERROR cycles
  logic          hresp;     // AHB ERROR response in progress

  modport exec (
    output state, buf_full,
    input  rd_done, rd_err, hresp
  );

  modport res (
    input  state,
    output rd_done, rd_err, hresp
  );

endinterface

/* rtl/read_result.sv */
/* Read completion for the bridge. Captures R data and RRESP while a read
   is pending and forms the two-cycle AHB ERROR response and HRDATA */
`timescale 1ns/1ps

module read_result import ahb_axi_pkg::*; (
  input  logic              bus_clk,
  input  logic              rst_l,
  bridge_rsp_if.res         rsp,
  input  logic              cmd_err,  // Decode check failed
  input  logic [data_w-1:0] rdata,
  input  logic [1:0]        rresp,
  input  logic              rvalid,
  output logic              rready,
  output logic [data_w-1:0] hrdata,
  output logic              hresp
);

  logic [data_w-1:0] rdata_q;     // Returned read data
  logic              err_first;   // Read error, first ERROR cycle
  logic              err_second;  // Read error, second ERROR cycle

  assign rready      = 1'b1;  // AHB blocks on reads, always room for R
  assign rsp.rd_done = rvalid & rready & (rsp.state == st_pend);

  // Data register, loaded only on the expected R beat
  always_ff @(posedge bus_clk) begin
    if (rsp.rd_done)
      rdata_q <= rdata;
  end

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      err_first  <= 1'b0;
      err_second <= 1'b0;
    end else begin
      err_first  <= rsp.rd_done & (rresp != resp_okay);  // SLVERR or DECERR
      err_second <= err_first;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AHB response
  //////////////////////////////////////////////////////////////////////

  // Decode error holds for the whole data phase, read error for two cycles
  assign rsp.rd_err = err_first | err_second;
  assign rsp.hresp  = cmd_err | rsp.rd_err;
  assign hresp      = rsp.hresp;
  assign hrdata     = rdata_q;

endmodule

/* sim/bridge_assertions.sv */
/* Protocol assertions for the bridge top level, bound into ahb_axi_bridge
   from the testbench */
`timescale 1ns/1ps

module bridge_assertions import ahb_axi_pkg::*; (
  input logic              bus_clk,
  input logic              rst_l,
  input logic              hreadyout,
  input logic              hresp,
  input logic [addr_w-1:0] awaddr,
  input logic              awvalid,
  input logic              awready,
  input logic [data_w-1:0] wdata,
  input logic [strb_w-1:0] wstrb,
  input logic              wvalid,
  input logic              wready,
  input logic [addr_w-1:0] araddr,
  input logic              arvalid,
  input logic              arready
);

  int fail_count = 0;  // Failed assertions so far

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite valid and payload hold until ready
  //////////////////////////////////////////////////////////////////////
  a_aw_hold: assert property (@(posedge bus_clk) disable iff (!rst_l)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      $error("AWVALID dropped or AWADDR moved before AWREADY");
      fail_count++;
    end

  a_w_hold: assert property (@(posedge bus_clk) disable iff (!rst_l)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else begin
      $error("WVALID dropped or W payload moved before WREADY");
      fail_count++;
    end

  a_ar_hold: assert property (@(posedge bus_clk) disable iff (!rst_l)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("ARVALID dropped or ARADDR moved before ARREADY");
      fail_count++;
    end

  // Two-cycle AHB ERROR, low ready first then high
  a_err_shape: assert property (@(posedge bus_clk) disable iff (!rst_l)
    hresp && !hreadyout |=> hresp && hreadyout)
    else begin
      $error("ERROR response not followed by its second cycle");
      fail_count++;
    end

  // Bus free straight out of reset
  a_reset_ready: assert property (@(posedge bus_clk) !rst_l |=> hreadyout)
    else begin
      $error("hreadyout low right after reset");
      fail_count++;
    end

endmodule

/* sim/tb_ahb_axi_bridge.sv */
/* Directed testbench for the AHB-Lite to AXI4-Lite bridge. Drives single
   AHB transfers and answers AXI from a small slave model with a memory */
`timescale 1ns/1ps

module tb_ahb_axi_bridge import ahb_axi_pkg::*; ();

  localparam int max_cycles = 2000;  // About four times the test length
  localparam int xfer_limit = 100;   // Per transfer or wait, in cycles

  logic bus_clk;
  logic rst_l;
  logic hsel, hwrite, hreadyin, hreadyout, hresp;
  logic [addr_w-1:0] haddr;
  logic [2:0] hsize;
  logic [1:0] htrans;
  logic [data_w-1:0] hwdata, hrdata;
  logic [addr_w-1:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bready, arvalid, arready, rvalid, rready;
  logic [data_w-1:0] wdata, rdata;
  logic [strb_w-1:0] wstrb;
  logic [1:0] rresp;

  // Slave model state
  logic [63:0] mem [logic [31:0]];      // Keyed by 8-byte line address
  logic [31:0] aw_q[$], ar_q[$], log_addr[$];
  logic [63:0] wd_q[$], log_data[$];
  logic [7:0]  ws_q[$], log_strb[$];
  int          aw_hs, w_hs, ar_hs;      // Handshake counts
  int          aw_hold;                 // Cycles left with AWREADY low
  int          rd_lat;                  // Cycles from AR to RVALID
  int          r_wait;
  logic        r_busy, r_fire;
  logic [1:0]  force_rresp;

  int          cycles;
  int          mismatch_cnt;
  int          fail_cnt;
  logic [31:0] lcg_state = 32'h4267_d4c8;

  tb_clock u_clock (
    .bus_clk (bus_clk),
    .rst_l   (rst_l)
  );

  ahb_axi_bridge UUT (
    .bus_clk   (bus_clk),
    .rst_l     (rst_l),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .htrans    (htrans),
    .hwdata    (hwdata),
    .hreadyin  (hreadyin),
    .hreadyout (hreadyout),
    .hrdata    (hrdata),
    .hresp     (hresp),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready)
  );

  bind ahb_axi_bridge bridge_assertions u_assertions (
    .bus_clk   (bus_clk),
    .rst_l     (rst_l),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Lanes from addr[2:0] up, 1 << size bytes wide
  function automatic logic [7:0] expected_strobe(logic [2:0] size, logic [31:0] addr);
    logic [7:0] lanes;
    int lo;
    int b;
    lanes = 8'h00;
    lo = int'(addr[2:0]);
    for (b = 0; b < 8; b++)
      if (b >= lo && b < lo + (1 << size)) lanes[b] = 1'b1;
    return lanes;
  endfunction

  function automatic logic [63:0] mem_read(logic [31:0] a);
    logic [31:0] line;
    line = {a[31:3], 3'b000};
    if (mem.exists(line)) return mem[line];
    return {~line, line};  // Unwritten lines, fill from the address
  endfunction

  function automatic void mem_write(logic [31:0] a, logic [63:0] d, logic [7:0] s);
    logic [63:0] cur;
    int b;
    cur = mem_read(a);
    for (b = 0; b < 8; b++)
      if (s[b]) cur[b*8 +: 8] = d[b*8 +: 8];
    mem[{a[31:3], 3'b000}] = cur;
  endfunction

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    mismatch_cnt++;
  endtask

  task automatic report_fail(string msg);
    $display("failure at %0t: %s", $time, msg);
    fail_cnt++;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge bus_clk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite slave model
  //////////////////////////////////////////////////////////////////////

  // Handshakes seen at the falling edge, all inputs settled
  always @(negedge bus_clk) begin
    logic [31:0] a;
    logic [63:0] d;
    logic [7:0]  s;
    if (rst_l) begin
      if (awvalid && awready) begin
        aw_q.push_back(awaddr);
        aw_hs++;
      end
      if (wvalid && wready) begin
        wd_q.push_back(wdata);
        ws_q.push_back(wstrb);
        w_hs++;
      end
      if (arvalid && arready) begin
        ar_q.push_back(araddr);
        ar_hs++;
      end
      r_fire = rvalid && rready;
      while (aw_q.size() > 0 && wd_q.size() > 0) begin  // AW and W pair in order
        a = aw_q.pop_front();
        d = wd_q.pop_front();
        s = ws_q.pop_front();
        mem_write(a, d, s);
        log_addr.push_back(a);
        log_data.push_back(d);
        log_strb.push_back(s);
      end
    end
  end

  // Ready and R drive, just after the rising edge
  always @(posedge bus_clk) begin
    logic [31:0] a;
    #1;
    if (aw_hold > 0) begin
      awready = 1'b0;
      aw_hold--;
    end else begin
      awready = 1'b1;
    end
    if (rvalid && r_fire) rvalid = 1'b0;  // Beat taken
    if (!rvalid && ar_q.size() > 0) begin
      if (!r_busy) begin
        r_busy = 1'b1;
        r_wait = rd_lat;
      end
      if (r_wait > 0) begin
        r_wait--;
      end else begin
        a      = ar_q.pop_front();
        rdata  = mem_read(a);
        rresp  = force_rresp;
        rvalid = 1'b1;
        r_busy = 1'b0;
      end
    end
  end

  // Watchdog
  always @(posedge bus_clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AHB master
  //////////////////////////////////////////////////////////////////////

  // One transfer, address phase then data phase, sampled at negedge
  task automatic ahb_xfer(input logic wr, input logic [2:0] size, input logic [31:0] addr,
                          input logic [63:0] wd, output logic [63:0] rd,
                          output logic got_err, output int waits);
    logic rdy;
    logic done;
    logic first_err;  // Last cycle was the first ERROR cycle
    int   n;
    rd        = '0;
    got_err   = 1'b0;
    waits     = 0;
    rdy       = 1'b0;
    done      = 1'b0;
    first_err = 1'b0;
    n         = 0;
    hsel   = 1'b1;
    htrans = nonseq;
    haddr  = addr;
    hwrite = wr;
    hsize  = size;
    while (!rdy && n < xfer_limit) begin
      @(negedge bus_clk);
      rdy = hreadyout;
      @(posedge bus_clk);
      #1;
      n++;
    end
    hsel   = 1'b0;
    htrans = idle;
    if (!rdy) begin
      report_fail("address phase was never accepted");
      return;
    end
    if (wr) hwdata = wd;  // Held for the whole data phase
    while (!done && n < xfer_limit) begin
      @(negedge bus_clk);
      if (first_err && !hresp) report_fail("hresp dropped after the first ERROR cycle");
      if (hreadyout) begin
        done    = 1'b1;
        rd      = hrdata;
        got_err = hresp;
        if (hresp && !first_err)
          report_fail("ERROR response ended without its first cycle");
      end else begin
        waits++;
      end
      first_err = hresp && !hreadyout;
      @(posedge bus_clk);
      #1;
      n++;
    end
    if (!done) report_fail("AHB transfer did not complete");
  endtask

  task automatic wait_for_writes(int count);
    int n;
    n = 0;
    while (log_addr.size() < count && n < xfer_limit) begin
      @(posedge bus_clk);
      #1;
      n++;
    end
    if (log_addr.size() < count) report_fail("write never reached the AXI slave");
  endtask

  // Stall AW, set between edges so the model sees it cleanly
  task automatic set_aw_stall(int n);
    @(negedge bus_clk);
    aw_hold = n;
    @(posedge bus_clk);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////
  task automatic check_reset_state();
    @(negedge bus_clk);
    if (hreadyout !== 1'b1) report_mismatch("hreadyout", 64'(hreadyout), 64'd1);
    if (hresp !== 1'b0) report_mismatch("hresp", 64'(hresp), 64'd0);
    if (awvalid !== 1'b0) report_mismatch("awvalid", 64'(awvalid), 64'd0);
    if (wvalid !== 1'b0) report_mismatch("wvalid", 64'(wvalid), 64'd0);
    if (arvalid !== 1'b0) report_mismatch("arvalid", 64'(arvalid), 64'd0);
    if (bready !== 1'b1) report_mismatch("bready", 64'(bready), 64'd1);
    if (rready !== 1'b1) report_mismatch("rready", 64'(rready), 64'd1);
    @(posedge bus_clk);
    #1;
  endtask

  task automatic test_write_sizes();
    logic [31:0] addrs [4];
    logic [2:0]  sizes [4];
    logic [63:0] wd, rd;
    logic        err;
    int          waits, base, i;
    addrs = '{32'hF004_0010, 32'hF004_0014, 32'hF004_0020, 32'hEE00_0100};
    sizes = '{3'd2, 3'd2, 3'd3, 3'd3};  // DCCM words, DCCM and ICCM dwords
    for (i = 0; i < 4; i++) begin
      wd   = {lcg_next(), lcg_next()};
      base = log_addr.size();
      ahb_xfer(1'b1, sizes[i], addrs[i], wd, rd, err, waits);
      if (err) report_fail("aligned write got an ERROR response");
      if (waits != 0) report_mismatch("write wait cycles", 64'(waits), 64'd0);
      wait_for_writes(base + 1);
      idle_cycles(4);
      if (log_addr.size() != base + 1) begin
        report_mismatch("write count", 64'(log_addr.size() - base), 64'd1);
      end else begin
        if (log_addr[base] !== addrs[i])
          report_mismatch("awaddr", 64'(log_addr[base]), 64'(addrs[i]));
        if (log_data[base] !== wd) report_mismatch("wdata", log_data[base], wd);
        if (log_strb[base] !== expected_strobe(sizes[i], addrs[i]))
          report_mismatch("wstrb", 64'(log_strb[base]), 64'(expected_strobe(sizes[i], addrs[i])));
      end
      if (aw_q.size() != 0 || wd_q.size() != 0)
        report_fail("AW and W handshakes did not pair up");
    end
  endtask

  task automatic test_read();
    logic [63:0] d0, d1, rd;
    logic        err;
    int          waits, ar0;
    d0  = {lcg_next(), lcg_next()};
    d1  = {lcg_next(), lcg_next()};
    mem[32'hEE00_0200] = d0;
    mem[32'hEE00_0208] = d1;
    ar0 = ar_hs;
    rd_lat = 0;
    ahb_xfer(1'b0, 3'd2, 32'hEE00_0200, '0, rd, err, waits);
    if (err) report_fail("ICCM word read got an ERROR response");
    if (rd !== d0) report_mismatch("hrdata", rd, d0);
    if (waits == 0) report_fail("read did not hold hreadyout low");
    rd_lat = 4;  // Slower slave
    ahb_xfer(1'b0, 3'd3, 32'hEE00_0208, '0, rd, err, waits);
    if (err) report_fail("ICCM dword read got an ERROR response");
    if (rd !== d1) report_mismatch("hrdata", rd, d1);
    rd_lat = 0;
    if (ar_hs != ar0 + 2) report_mismatch("AR handshakes", 64'(ar_hs - ar0), 64'd2);
  endtask

  task automatic test_decode_errors();
    logic [31:0] addrs [5];
    logic [2:0]  sizes [5];
    logic [4:0]  wr_mask;
    logic [63:0] rd;
    logic        err;
    int          waits, aw0, w0, ar0, i;
    addrs   = '{32'h1000_0000, 32'hF004_0002, 32'hEE00_0010, 32'hEE00_0011, 32'hF004_0004};
    sizes   = '{3'd2, 3'd2, 3'd1, 3'd0, 3'd3};
    wr_mask = 5'b10101;  // Bit i set for a write
    aw0 = aw_hs;
    w0  = w_hs;
    ar0 = ar_hs;
    for (i = 0; i < 5; i++) begin
      ahb_xfer(wr_mask[i], sizes[i], addrs[i], {lcg_next(), lcg_next()}, rd, err, waits);
      if (!err) report_fail("bad address, size or alignment did not give an ERROR response");
    end
    idle_cycles(4);
    if (aw_hs != aw0) report_mismatch("AW handshakes", 64'(aw_hs - aw0), 64'd0);
    if (w_hs != w0) report_mismatch("W handshakes", 64'(w_hs - w0), 64'd0);
    if (ar_hs != ar0) report_mismatch("AR handshakes", 64'(ar_hs - ar0), 64'd0);
  endtask

  task automatic test_read_error();
    logic [63:0] rd;
    logic        err;
    int          waits;
    force_rresp = 2'b10;  // SLVERR
    ahb_xfer(1'b0, 3'd2, 32'hEE00_0300, '0, rd, err, waits);
    if (!err) report_fail("SLVERR read did not give an ERROR response");
    force_rresp = resp_okay;
  endtask

  task automatic test_backpressure();
    logic [63:0] d0, d1, rd;
    logic        e0, e1;
    int          w0, w1, base;
    d0   = {lcg_next(), lcg_next()};
    d1   = {lcg_next(), lcg_next()};
    base = log_addr.size();
    set_aw_stall(10);
    ahb_xfer(1'b1, 3'd3, 32'hF004_0100, d0, rd, e0, w0);
    ahb_xfer(1'b1, 3'd3, 32'hF004_0108, d1, rd, e1, w1);
    if (e0 || e1) report_fail("write under back-pressure got an ERROR response");
    if (w0 != 0) report_mismatch("first write wait cycles", 64'(w0), 64'd0);
    if (w1 == 0) report_fail("second write did not stall while the buffer was full");
    wait_for_writes(base + 2);
    idle_cycles(4);
    if (log_addr.size() == base + 2) begin
      if (log_addr[base] !== 32'hF004_0100)
        report_mismatch("awaddr", 64'(log_addr[base]), 64'hF004_0100);
      if (log_data[base] !== d0) report_mismatch("wdata", log_data[base], d0);
      if (log_addr[base+1] !== 32'hF004_0108)
        report_mismatch("awaddr", 64'(log_addr[base+1]), 64'hF004_0108);
      if (log_data[base+1] !== d1) report_mismatch("wdata", log_data[base+1], d1);
    end else begin
      report_mismatch("write count", 64'(log_addr.size() - base), 64'd2);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    hsel        = 1'b0;
    haddr       = '0;
    hwrite      = 1'b0;
    hsize       = 3'd0;
    htrans      = idle;
    hwdata      = '0;
    hreadyin    = 1'b1;  // Only slave on the bus
    awready     = 1'b1;
    wready      = 1'b1;
    arready     = 1'b1;
    rdata       = '0;
    rresp       = resp_okay;
    rvalid      = 1'b0;
    aw_hold     = 0;
    rd_lat      = 0;
    r_wait      = 0;
    r_busy      = 1'b0;
    r_fire      = 1'b0;
    force_rresp = resp_okay;
    wait (rst_l === 1'b1);
    @(posedge bus_clk);
    #1;
    check_reset_state();
    test_write_sizes();
    test_read();
    test_decode_errors();
    test_read_error();
    test_backpressure();
    idle_cycles(5);
    $display("mismatches: %0d, other failures: %0d, assertion failures: %0d",
             mismatch_cnt, fail_cnt, UUT.u_assertions.fail_count);
    if (mismatch_cnt == 0 && fail_cnt == 0 && UUT.u_assertions.fail_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* sim/tb_clock.sv */
/* Testbench clock and reset source, an 8 ns bus_clk with rst_l held
   low for the first 16 rising edges */
`timescale 1ns/1ps

module tb_clock (
  output logic bus_clk,
  output logic rst_l
);

  localparam int reset_cycles = 16;

  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;  // 8 ns period
  end

  initial begin
    rst_l = 1'b0;
    repeat (reset_cycles) @(posedge bus_clk);
    #1 rst_l = 1'b1;  // Release just after an edge
  end

endmodule

/* vlog.f */
rtl/ahb_axi_pkg.sv
rtl/bridge_cmd_if.sv
rtl/bridge_rsp_if.sv
rtl/ahb_decode.sv
rtl/bridge_execute.sv
rtl/read_result.sv
rtl/ahb_axi_bridge.sv
sim/tb_clock.sv
sim/bridge_assertions.sv
sim/tb_ahb_axi_bridge.sv
